// File: Bender.yml
package:
  name: axilite_noc_bridge

export_include_dirs:
  - logic

sources:
  - logic/noc_msg_pkg.sv
  - logic/axi_lite_pkg.sv
  - logic/sync_fifo.sv
  - logic/axi_request_queue.sv
  - logic/strb_to_size.sv
  - logic/noc_request_encoder.sv
  - logic/noc_response_decoder.sv
  - logic/axilite_noc_bridge.sv
  - target: test
    files:
      - test/bridge_tb.sv

// File: files.f
+incdir+logic
logic/noc_msg_pkg.sv
logic/axi_lite_pkg.sv
logic/sync_fifo.sv
logic/axi_request_queue.sv
logic/strb_to_size.sv
logic/noc_request_encoder.sv
logic/noc_response_decoder.sv
logic/axilite_noc_bridge.sv
test/bridge_tb.sv

// File: logic/axi_lite_pkg.sv
`default_nettype none
`include "bridge_defines.svh"

package axi_lite_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [`AXI_DATA_WIDTH/8-1:0] axi_strb_t;
    typedef logic [1:0] axi_resp_t;

    // kind of a queued request
    typedef enum logic {
        REQ_LOAD,
        REQ_STORE
    } req_kind_t;

endpackage

`default_nettype wire

// File: logic/axi_request_queue.sv
`default_nettype none
`include "bridge_defines.svh"

module axi_request_queue (
    input  wire                     clk,
    input  wire                     rst,
    input  wire axi_lite_pkg::axi_addr_t awaddr,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire axi_lite_pkg::axi_data_t wdata,
    input  wire axi_lite_pkg::axi_strb_t wstrb,
    input  wire                     wvalid,
    output logic                    wready,
    input  wire axi_lite_pkg::axi_addr_t araddr,
    input  wire                     arvalid,
    output logic                    arready,
    input  wire                     req_done,
    output logic                    req_valid,
    output axi_lite_pkg::req_kind_t req_kind,
    output axi_lite_pkg::axi_addr_t req_addr,
    output axi_lite_pkg::axi_data_t req_data,
    output axi_lite_pkg::axi_strb_t req_strb
);

    localparam int WQ_WIDTH = $bits(axi_lite_pkg::axi_addr_t) + $bits(axi_lite_pkg::axi_data_t)
                              + $bits(axi_lite_pkg::axi_strb_t);

    logic wq_full;
    logic wq_empty;
    logic [WQ_WIDTH-1:0] wq_dout;
    axi_lite_pkg::axi_addr_t w_addr;
    logic rq_full;
    logic rq_empty;
    axi_lite_pkg::axi_addr_t r_addr;
    logic kq_empty;
    logic [0:0] kq_dout;
    logic wr_pair;
    logic wr_acc;
    logic rd_acc;
    logic is_store;

    assign wr_pair = awvalid && wvalid;
    assign wr_acc = wr_pair && !wq_full;
    assign rd_acc = arvalid && !wr_pair && !rq_full;  // writes win ties
    assign awready = wr_acc;
    assign wready = wr_acc;
    assign arready = rd_acc;

    assign req_valid = !kq_empty;
    assign req_kind = axi_lite_pkg::req_kind_t'(kq_dout);
    assign is_store = (req_kind == axi_lite_pkg::REQ_STORE);
    assign {w_addr, req_data, req_strb} = wq_dout;
    assign req_addr = is_store ? w_addr : r_addr;

    sync_fifo #(.WIDTH(WQ_WIDTH), .DEPTH(`REQ_QUEUE_DEPTH)) write_q (
        .clk(clk), .rst(rst),
        .wr_en(wr_acc), .wr_data({awaddr, wdata, wstrb}), .full(wq_full),
        .rd_en(req_done && is_store), .rd_data(wq_dout), .empty(wq_empty)
    );

    sync_fifo #(.WIDTH($bits(axi_lite_pkg::axi_addr_t)), .DEPTH(`REQ_QUEUE_DEPTH)) read_q (
        .clk(clk), .rst(rst),
        .wr_en(rd_acc), .wr_data(araddr), .full(rq_full),
        .rd_en(req_done && !is_store), .rd_data(r_addr), .empty(rq_empty)
    );

    // arrival order across both kinds, deep enough for both payload queues
    sync_fifo #(.WIDTH(1), .DEPTH(2 * `REQ_QUEUE_DEPTH)) kind_q (
        .clk(clk), .rst(rst),
        .wr_en(wr_acc || rd_acc), .wr_data(wr_acc ? 1'b1 : 1'b0), .full(),
        .rd_en(req_done), .rd_data(kq_dout), .empty(kq_empty)
    );

    // head request must have its payload queued
    assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (is_store ? !wq_empty : !rq_empty))
        else $error("kind queue out of step with payload queues");

endmodule

`default_nettype wire

// File: logic/axilite_noc_bridge.sv
`default_nettype none

module axilite_noc_bridge (
    input  wire                          clk,
    input  wire                          rst,
    // axi-lite manager side
    input  wire axi_lite_pkg::axi_addr_t awaddr,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire axi_lite_pkg::axi_data_t wdata,
    input  wire axi_lite_pkg::axi_strb_t wstrb,
    input  wire                          wvalid,
    output logic                         wready,
    input  wire axi_lite_pkg::axi_addr_t araddr,
    input  wire                          arvalid,
    output logic                         arready,
    output axi_lite_pkg::axi_data_t      rdata,
    output axi_lite_pkg::axi_resp_t      rresp,
    output logic                         rvalid,
    input  wire                          rready,
    output axi_lite_pkg::axi_resp_t      bresp,
    output logic                         bvalid,
    input  wire                          bready,
    // noc side
    output logic                         noc2_valid_out,
    output noc_msg_pkg::noc_flit_t       noc2_data_out,
    input  wire                          noc2_ready_in,
    input  wire                          noc3_valid_in,
    input  wire noc_msg_pkg::noc_flit_t  noc3_data_in,
    output logic                         noc3_ready_out,
    input  wire noc_msg_pkg::chipid_t    src_chipid,
    input  wire noc_msg_pkg::xpos_t      src_xpos,
    input  wire noc_msg_pkg::ypos_t      src_ypos,
    input  wire noc_msg_pkg::fbits_t     src_fbits,
    input  wire noc_msg_pkg::chipid_t    dest_chipid,
    input  wire noc_msg_pkg::xpos_t      dest_xpos,
    input  wire noc_msg_pkg::ypos_t      dest_ypos,
    input  wire noc_msg_pkg::fbits_t     dest_fbits
);

    logic req_valid;
    logic req_done;
    axi_lite_pkg::req_kind_t req_kind;
    axi_lite_pkg::axi_addr_t req_addr;
    axi_lite_pkg::axi_data_t req_data;
    axi_lite_pkg::axi_strb_t req_strb;
    logic strb_valid;
    logic size_valid;
    logic size_taken;
    noc_msg_pkg::data_size_t size;
    noc_msg_pkg::byte_offset_t offset;

    axi_request_queue req_queue (.*);

    // strobe of the head store goes through the converter
    strb_to_size strb_conv (.*, .strb(req_strb));

    noc_request_encoder encoder (.*);

    noc_response_decoder decoder (.*);

endmodule

`default_nettype wire

// File: logic/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

`define NOC_FLIT_WIDTH 64
`define AXI_ADDR_WIDTH 48
`define AXI_DATA_WIDTH 64
`define REQ_QUEUE_DEPTH 16  // per request kind

// noc message types
`define MSG_TYPE_NC_LOAD_REQ 14
`define MSG_TYPE_NC_STORE_REQ 15
`define MSG_TYPE_NC_LOAD_MEM_ACK 26
`define MSG_TYPE_NC_STORE_MEM_ACK 27

// data size codes
`define DATA_SIZE_1B 3'd1
`define DATA_SIZE_2B 3'd2
`define DATA_SIZE_4B 3'd3
`define DATA_SIZE_8B 3'd4

`define CHIPID_WIDTH 14
`define XPOS_WIDTH 8
`define YPOS_WIDTH 8
`define FBITS_WIDTH 4
`define MSG_LEN_WIDTH 8
`define MSG_TYPE_WIDTH 8
`define MSHRID_WIDTH 8
`define DATA_SIZE_WIDTH 3

// field positions in header flit 0
`define MSG_LEN_LSB 22
`define MSG_TYPE_LSB 14

`endif

// File: logic/noc_msg_pkg.sv
`default_nettype none
`include "bridge_defines.svh"

package noc_msg_pkg;

    typedef logic [`NOC_FLIT_WIDTH-1:0] noc_flit_t;

    // node coordinates
    typedef logic [`CHIPID_WIDTH-1:0] chipid_t;
    typedef logic [`XPOS_WIDTH-1:0] xpos_t;
    typedef logic [`YPOS_WIDTH-1:0] ypos_t;
    typedef logic [`FBITS_WIDTH-1:0] fbits_t;

    typedef logic [`MSG_LEN_WIDTH-1:0] msg_len_t;  // flits after header 0
    typedef logic [`MSG_TYPE_WIDTH-1:0] msg_type_t;
    typedef logic [`DATA_SIZE_WIDTH-1:0] data_size_t;
    typedef logic [$clog2(`AXI_DATA_WIDTH/8)-1:0] byte_offset_t;  // byte lane in a word

endpackage

`default_nettype wire

// File: logic/noc_request_encoder.sv
`default_nettype none
`include "bridge_defines.svh"

module noc_request_encoder (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           req_valid,
    input  wire axi_lite_pkg::req_kind_t  req_kind,
    input  wire axi_lite_pkg::axi_addr_t  req_addr,
    input  wire axi_lite_pkg::axi_data_t  req_data,
    input  wire                           size_valid,
    input  wire noc_msg_pkg::data_size_t  size,
    input  wire noc_msg_pkg::byte_offset_t offset,
    input  wire                           noc2_ready_in,
    input  wire noc_msg_pkg::chipid_t     src_chipid,
    input  wire noc_msg_pkg::xpos_t       src_xpos,
    input  wire noc_msg_pkg::ypos_t       src_ypos,
    input  wire noc_msg_pkg::fbits_t      src_fbits,
    input  wire noc_msg_pkg::chipid_t     dest_chipid,
    input  wire noc_msg_pkg::xpos_t       dest_xpos,
    input  wire noc_msg_pkg::ypos_t       dest_ypos,
    input  wire noc_msg_pkg::fbits_t      dest_fbits,
    output logic                          req_done,
    output logic                          strb_valid,
    output logic                          size_taken,
    output logic                          noc2_valid_out,
    output noc_msg_pkg::noc_flit_t        noc2_data_out
);

    typedef enum logic [1:0] {IDLE, WAIT_SIZE, HEADER, DATA} state_t;

    state_t state;
    logic [1:0] flit_cnt;  // header flit index
    logic is_store;
    logic fire;
    logic last_hdr;
    noc_msg_pkg::msg_len_t msg_len;
    noc_msg_pkg::msg_type_t msg_type;
    noc_msg_pkg::data_size_t msg_size;
    axi_lite_pkg::axi_addr_t msg_addr;

    assign is_store = (req_kind == axi_lite_pkg::REQ_STORE);
    assign noc2_valid_out = (state == HEADER) || (state == DATA);
    assign fire = noc2_valid_out && noc2_ready_in;
    assign last_hdr = (state == HEADER) && (flit_cnt == 2'd2);
    assign req_done = fire && ((last_hdr && !is_store) || (state == DATA));
    assign strb_valid = (state == IDLE) && req_valid && is_store;
    assign size_taken = req_done && is_store;  // frees the converter

    // store: 2 more headers + 1 data flit, load: 2 more headers
    assign msg_len = is_store ? noc_msg_pkg::msg_len_t'(3) : noc_msg_pkg::msg_len_t'(2);
    assign msg_type = is_store ? noc_msg_pkg::msg_type_t'(`MSG_TYPE_NC_STORE_REQ)
                               : noc_msg_pkg::msg_type_t'(`MSG_TYPE_NC_LOAD_REQ);
    assign msg_size = is_store ? size : `DATA_SIZE_8B;
    assign msg_addr = is_store ? {req_addr[`AXI_ADDR_WIDTH-1:3], offset} : req_addr;

    always_comb begin
        case (state)
            HEADER: begin
                case (flit_cnt)
                    2'd0: noc2_data_out = {dest_chipid, dest_xpos, dest_ypos, dest_fbits,
                                           msg_len, msg_type, {`MSHRID_WIDTH{1'b0}}, 6'b0};
                    2'd1: noc2_data_out = {5'b0, msg_addr, 8'b0, msg_size};
                    default: noc2_data_out = {src_chipid, src_xpos, src_ypos, src_fbits, 30'b0};
                endcase
            end
            DATA: noc2_data_out = req_data;
            default: noc2_data_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            flit_cnt <= '0;
        end else begin
            case (state)
                IDLE: if (req_valid) state <= is_store ? WAIT_SIZE : HEADER;
                WAIT_SIZE: if (size_valid) state <= HEADER;
                HEADER: begin
                    if (fire) begin
                        flit_cnt <= last_hdr ? 2'd0 : flit_cnt + 2'd1;
                        if (last_hdr) state <= is_store ? DATA : IDLE;
                    end
                end
                DATA: if (fire) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // flit holds while the network stalls
    assert property (@(posedge clk) disable iff (rst)
        noc2_valid_out && !noc2_ready_in |=> noc2_valid_out && $stable(noc2_data_out))
        else $error("noc2 flit changed while stalled");

endmodule

`default_nettype wire

// File: logic/noc_response_decoder.sv
`default_nettype none
`include "bridge_defines.svh"

module noc_response_decoder (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           noc3_valid_in,
    input  wire noc_msg_pkg::noc_flit_t   noc3_data_in,
    output logic                          noc3_ready_out,
    output axi_lite_pkg::axi_data_t       rdata,
    output axi_lite_pkg::axi_resp_t       rresp,
    output logic                          rvalid,
    input  wire                           rready,
    output axi_lite_pkg::axi_resp_t       bresp,
    output logic                          bvalid,
    input  wire                           bready
);

    typedef enum logic [1:0] {HEAD, DATA, RESP} state_t;

    state_t state;
    noc_msg_pkg::msg_len_t remain;  // flits left in this message
    noc_msg_pkg::msg_len_t hdr_len;
    noc_msg_pkg::msg_type_t hdr_type;
    logic is_load_ack;
    logic is_store_ack;
    logic load_rsp;
    logic fire;

    assign hdr_len = noc3_data_in[`MSG_LEN_LSB +: `MSG_LEN_WIDTH];
    assign hdr_type = noc3_data_in[`MSG_TYPE_LSB +: `MSG_TYPE_WIDTH];
    assign is_load_ack = (hdr_type == `MSG_TYPE_NC_LOAD_MEM_ACK);
    assign is_store_ack = (hdr_type == `MSG_TYPE_NC_STORE_MEM_ACK);
    assign noc3_ready_out = (state != RESP);  // stall while the manager owes a handshake
    assign fire = noc3_valid_in && noc3_ready_out;
    assign rresp = '0;  // always okay
    assign bresp = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HEAD;
            remain <= '0;
            load_rsp <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            case (state)
                HEAD: begin
                    if (fire) begin
                        remain <= hdr_len;
                        load_rsp <= is_load_ack && (hdr_len == 8'd1);
                        if (hdr_len != '0) begin
                            state <= DATA;
                        end else if (is_store_ack) begin
                            state <= RESP;
                            bvalid <= 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (fire) begin
                        remain <= remain - 1'b1;
                        if (remain == 8'd1) begin
                            state <= load_rsp ? RESP : HEAD;  // other shapes just drain
                            rvalid <= load_rsp;
                        end
                    end
                end
                RESP: begin
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        state <= HEAD;
                        rvalid <= 1'b0;
                        bvalid <= 1'b0;
                    end
                end
                default: state <= HEAD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && fire && load_rsp) rdata <= noc3_data_in;
    end

    assert property (@(posedge clk) disable iff (rst)
        fire && state == HEAD |-> is_load_ack || is_store_ack)
        else $error("unknown noc3 message type %0d", hdr_type);

endmodule

`default_nettype wire

// File: logic/strb_to_size.sv
`default_nettype none
`include "bridge_defines.svh"

module strb_to_size (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          strb_valid,
    input  wire axi_lite_pkg::axi_strb_t strb,
    input  wire                          size_taken,
    output logic                         size_valid,
    output noc_msg_pkg::data_size_t      size,
    output noc_msg_pkg::byte_offset_t    offset
);

    logic strb_legal;
    noc_msg_pkg::data_size_t next_size;
    noc_msg_pkg::byte_offset_t next_offset;

    // aligned power-of-two runs only, else full word
    always_comb begin
        strb_legal = 1'b0;
        next_size = `DATA_SIZE_8B;
        next_offset = '0;
        for (int i = 0; i < 8; i++) begin
            if (strb == (8'h01 << i)) begin
                strb_legal = 1'b1;
                next_size = `DATA_SIZE_1B;
                next_offset = noc_msg_pkg::byte_offset_t'(i);
            end
        end
        for (int i = 0; i < 8; i += 2) begin
            if (strb == (8'h03 << i)) begin
                strb_legal = 1'b1;
                next_size = `DATA_SIZE_2B;
                next_offset = noc_msg_pkg::byte_offset_t'(i);
            end
        end
        for (int i = 0; i < 8; i += 4) begin
            if (strb == (8'h0F << i)) begin
                strb_legal = 1'b1;
                next_size = `DATA_SIZE_4B;
                next_offset = noc_msg_pkg::byte_offset_t'(i);
            end
        end
        if (strb == 8'hFF) strb_legal = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) size_valid <= 1'b0;
        else if (strb_valid) size_valid <= 1'b1;
        else if (size_taken) size_valid <= 1'b0;  // held until the store is sent
    end

    always_ff @(posedge clk) begin
        if (strb_valid) begin
            size <= next_size;
            offset <= next_offset;
        end
    end

    assert property (@(posedge clk) disable iff (rst) strb_valid |-> strb_legal)
        else $error("write strobe %h is not an aligned power-of-two run", strb);

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              wr_en,
    input  wire [WIDTH-1:0]  wr_data,
    output logic             full,
    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;

    assign full = (count == DEPTH);
    assign empty = (count == '0);
    assign rd_data = mem[rd_ptr];  // head always visible

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
        else $error("sync_fifo: write while full");
    assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// File: test/bridge_tb.sv
`default_nettype none
`include "bridge_defines.svh"

module bridge_tb;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;

    localparam noc_msg_pkg::chipid_t SRC_CHIPID = 14'h0012;
    localparam noc_msg_pkg::xpos_t SRC_X = 8'h03;
    localparam noc_msg_pkg::ypos_t SRC_Y = 8'h04;
    localparam noc_msg_pkg::fbits_t SRC_FBITS = 4'h0;
    localparam noc_msg_pkg::chipid_t DEST_CHIPID = 14'h0001;
    localparam noc_msg_pkg::xpos_t DEST_X = 8'h05;
    localparam noc_msg_pkg::ypos_t DEST_Y = 8'h06;
    localparam noc_msg_pkg::fbits_t DEST_FBITS = 4'ha;

    logic clk = 1'b0;
    logic rst;
    axi_lite_pkg::axi_addr_t awaddr;
    logic awvalid;
    logic awready;
    axi_lite_pkg::axi_data_t wdata;
    axi_lite_pkg::axi_strb_t wstrb;
    logic wvalid;
    logic wready;
    axi_lite_pkg::axi_addr_t araddr;
    logic arvalid;
    logic arready;
    axi_lite_pkg::axi_data_t rdata;
    axi_lite_pkg::axi_resp_t rresp;
    logic rvalid;
    logic rready;
    axi_lite_pkg::axi_resp_t bresp;
    logic bvalid;
    logic bready;
    logic noc2_valid_out;
    noc_msg_pkg::noc_flit_t noc2_data_out;
    logic noc2_ready_in;
    logic noc3_valid_in;
    noc_msg_pkg::noc_flit_t noc3_data_in;
    logic noc3_ready_out;

    logic [31:0] rng = 32'd17;
    noc_msg_pkg::noc_flit_t got[$];  // flits of the last collected message

    axilite_noc_bridge dut0 (
        .*,
        .src_chipid(SRC_CHIPID), .src_xpos(SRC_X), .src_ypos(SRC_Y), .src_fbits(SRC_FBITS),
        .dest_chipid(DEST_CHIPID), .dest_xpos(DEST_X), .dest_ypos(DEST_Y),
        .dest_fbits(DEST_FBITS)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic axi_lite_pkg::axi_addr_t random_addr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[15:0], lo};
    endfunction

    function automatic axi_lite_pkg::axi_data_t random_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    function automatic noc_msg_pkg::noc_flit_t header0(input int len, input int mtype);
        return {DEST_CHIPID, DEST_X, DEST_Y, DEST_FBITS, 8'(len), 8'(mtype), 8'h00, 6'b0};
    endfunction

    function automatic noc_msg_pkg::noc_flit_t header1(input axi_lite_pkg::axi_addr_t addr,
                                                       input noc_msg_pkg::data_size_t size);
        return {5'b0, addr, 8'b0, size};
    endfunction

    function automatic noc_msg_pkg::noc_flit_t header2();
        return {SRC_CHIPID, SRC_X, SRC_Y, SRC_FBITS, 30'b0};
    endfunction

    // size from the byte count, offset from the lowest enabled lane
    function automatic void expected_size(input axi_lite_pkg::axi_strb_t strb,
                                          output noc_msg_pkg::data_size_t size,
                                          output noc_msg_pkg::byte_offset_t off);
        int ones;
        ones = $countones(strb);
        case (ones)
            1: size = `DATA_SIZE_1B;
            2: size = `DATA_SIZE_2B;
            4: size = `DATA_SIZE_4B;
            default: size = `DATA_SIZE_8B;
        endcase
        off = '0;
        for (int i = 7; i >= 0; i--) begin
            if (strb[i]) off = noc_msg_pkg::byte_offset_t'(i);
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR @%0t %s: got %h expected %h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input axi_lite_pkg::axi_addr_t addr,
                             input axi_lite_pkg::axi_data_t data,
                             input axi_lite_pkg::axi_strb_t strb);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
    endtask

    task automatic axi_read(input axi_lite_pkg::axi_addr_t addr);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
    endtask

    // noc2 ready stays low between messages
    // stall_at of 0 means no stall
    task automatic collect_msg(input int n, input int stall_at);
        noc_msg_pkg::noc_flit_t held;
        got.delete();
        @(posedge clk);
        noc2_ready_in <= 1'b1;
        while (got.size() < n) begin
            @(negedge clk);
            if (noc2_valid_out && noc2_ready_in) begin
                got.push_back(noc2_data_out);
                if (got.size() == stall_at) begin
                    @(posedge clk);
                    noc2_ready_in <= 1'b0;
                    @(negedge clk);
                    held = noc2_data_out;
                    repeat (3) begin
                        @(negedge clk);
                        check_value("noc2_valid_out", noc2_valid_out, 1'b1);
                        check_value("noc2_data_out", noc2_data_out, held);
                    end
                    @(posedge clk);
                    noc2_ready_in <= 1'b1;
                end
            end
        end
        @(posedge clk);
        noc2_ready_in <= 1'b0;  // last flit moves on this edge
    endtask

    task automatic expect_load(input axi_lite_pkg::axi_addr_t addr, input int stall_at);
        collect_msg(3, stall_at);
        check_value("load flit0", got[0], header0(2, `MSG_TYPE_NC_LOAD_REQ));
        check_value("load flit1", got[1], header1(addr, `DATA_SIZE_8B));
        check_value("load flit2", got[2], header2());
    endtask

    task automatic expect_store(input axi_lite_pkg::axi_addr_t addr,
                                input axi_lite_pkg::axi_data_t data,
                                input axi_lite_pkg::axi_strb_t strb, input int stall_at);
        noc_msg_pkg::data_size_t size;
        noc_msg_pkg::byte_offset_t off;
        expected_size(strb, size, off);
        collect_msg(4, stall_at);
        check_value("store flit0", got[0], header0(3, `MSG_TYPE_NC_STORE_REQ));
        check_value("store flit1", got[1], header1({addr[47:3], off}, size));
        check_value("store flit2", got[2], header2());
        check_value("store data flit", got[3], data);
    endtask

    task automatic send_flit(input noc_msg_pkg::noc_flit_t flit);
        @(posedge clk);
        noc3_data_in <= flit;
        noc3_valid_in <= 1'b1;
        do @(negedge clk); while (!noc3_ready_out);
        @(posedge clk);
        noc3_valid_in <= 1'b0;
    endtask

    task automatic test_after_reset();
        axi_lite_pkg::axi_addr_t addr;
        addr = random_addr();
        @(negedge clk);
        check_value("noc2_valid_out", noc2_valid_out, 1'b0);
        check_value("rvalid", rvalid, 1'b0);
        check_value("bvalid", bvalid, 1'b0);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        check_value("arready", arready, 1'b1);
        @(posedge clk);
        arvalid <= 1'b0;
        expect_load(addr, 0);
    endtask

    task automatic test_read();
        axi_lite_pkg::axi_addr_t addr;
        addr = random_addr();
        axi_read(addr);
        expect_load(addr, 0);
    endtask

    task automatic test_write_full();
        axi_lite_pkg::axi_addr_t addr;
        axi_lite_pkg::axi_data_t data;
        addr = random_addr();
        data = random_data();
        axi_write(addr, data, 8'hff);
        expect_store(addr, data, 8'hff, 0);
    endtask

    task automatic test_write_strobes();
        axi_lite_pkg::axi_strb_t strobes[4] = '{8'h01, 8'h0c, 8'hf0, 8'h80};
        axi_lite_pkg::axi_addr_t addr;
        axi_lite_pkg::axi_data_t data;
        foreach (strobes[i]) begin
            addr = random_addr();
            data = random_data();
            axi_write(addr, data, strobes[i]);
            expect_store(addr, data, strobes[i], 0);
        end
    endtask

    task automatic test_responses();
        axi_lite_pkg::axi_data_t data;
        data = random_data();
        send_flit(header0(1, `MSG_TYPE_NC_LOAD_MEM_ACK));
        send_flit(data);
        do @(negedge clk); while (!rvalid);
        repeat (3) begin
            check_value("rdata", rdata, data);
            check_value("rresp", rresp, 2'b00);
            check_value("noc3_ready_out", noc3_ready_out, 1'b0);
            @(negedge clk);
            check_value("rvalid", rvalid, 1'b1);  // held without rready
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_value("rvalid", rvalid, 1'b0);
        send_flit(header0(0, `MSG_TYPE_NC_STORE_MEM_ACK));
        do @(negedge clk); while (!bvalid);
        repeat (3) begin
            check_value("bresp", bresp, 2'b00);
            check_value("noc3_ready_out", noc3_ready_out, 1'b0);
            @(negedge clk);
            check_value("bvalid", bvalid, 1'b1);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        check_value("bvalid", bvalid, 1'b0);
        check_value("noc3_ready_out", noc3_ready_out, 1'b1);
    endtask

    // write and read offered together, with noc2 stalls mid-message
    task automatic test_stall_and_order();
        axi_lite_pkg::axi_addr_t waddr;
        axi_lite_pkg::axi_addr_t raddr;
        axi_lite_pkg::axi_data_t data;
        waddr = random_addr();
        raddr = random_addr();
        data = random_data();
        @(posedge clk);
        awaddr <= waddr;
        wdata <= data;
        wstrb <= 8'hff;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        araddr <= raddr;
        arvalid <= 1'b1;
        @(negedge clk);
        check_value("awready on tie", awready, 1'b1);
        check_value("wready on tie", wready, 1'b1);
        check_value("arready on tie", arready, 1'b0);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        expect_store(waddr, data, 8'hff, 2);
        expect_load(raddr, 1);
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    initial begin
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        bready = 1'b0;
        noc2_ready_in = 1'b0;
        noc3_valid_in = 1'b0;
        noc3_data_in = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_after_reset();
        test_read();
        test_write_full();
        test_write_strobes();
        test_responses();
        test_stall_and_order();
        repeat (2) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
